// File: csr.f
rtl/csrPkg.sv
rtl/csrWriteIf.sv
rtl/csrStatus.sv
rtl/csrInterrupt.sv
rtl/csrCounter.sv
rtl/csrMachine.sv
rtl/csr.sv
verif/csrTb.sv

// File: Bender.yml
package:
  name: csr

sources:
  - rtl/csrPkg.sv
  - rtl/csrWriteIf.sv
  - rtl/csrStatus.sv
  - rtl/csrInterrupt.sv
  - rtl/csrCounter.sv
  - rtl/csrMachine.sv
  - rtl/csr.sv
  - target: test
    files:
      - verif/csrTb.sv

// File: verif/csrVectors.txt
# name ctl(valid,stall,flush) instr pc srcA ops(rd,wr,trap,int,mret) cause badAdr priv
# ints(mTi,mEi,mSi) gap | expPcNext expIllegal expIntPending expReadValW (next cycle, x = skip)
wrScratch   100 340090F3 00000100 12345678 11000 0 00000000 3 000 1 00000104 0 0 00000000
setScratch  100 3400A0F3 00000104 0000FF00 11000 0 00000000 3 000 1 00000108 0 0 12345678
clrScratch  100 3400B0F3 00000108 12000000 11000 0 00000000 3 000 1 0000010C 0 0 1234FF78
setImm      100 3402E0F3 0000010C 00000000 11000 0 00000000 3 000 1 00000110 0 0 0034FF78
clrImm      100 340E70F3 00000110 00000000 11000 0 00000000 3 000 1 00000114 0 0 0034FF7D
rdScratch   100 340020F3 00000114 00000000 10000 0 00000000 3 000 1 00000118 0 0 0034FF61
illUnknown  100 7C0020F3 00000118 00000000 10000 0 00000000 3 000 1 0000011C 1 0 00000000
illUser     100 340020F3 0000011C 00000000 10000 0 00000000 0 000 1 00000120 1 0 0034FF61
illRoWrite  100 F14010F3 00000120 00000000 11000 0 00000000 3 000 1 00000124 1 0 00000000
legalRead   100 300020F3 00000124 00000000 10000 0 00000000 3 000 1 00000128 0 0 00001800
setTvec     100 305090F3 00000128 00000200 11000 0 00000000 3 000 1 0000012C 0 0 00000000
setMstatus  100 300090F3 0000012C 00001808 11000 0 00000000 3 000 1 00000130 0 0 00001800
trapLoad    100 00000013 00000400 00000000 00100 5 DEADBEE0 3 000 1 00000200 0 0 00000000
rdMepc      100 341020F3 00000200 00000000 10000 0 00000000 3 000 1 00000204 0 0 00000400
rdMcause    100 342020F3 00000204 00000000 10000 0 00000000 3 000 1 00000208 0 0 00000005
rdMtval     100 343020F3 00000208 00000000 10000 0 00000000 3 000 1 0000020C 0 0 DEADBEE0
rdMstatus   100 300020F3 0000020C 00000000 10000 0 00000000 3 000 1 00000210 0 0 00001880
setVecMode  100 305090F3 00000210 00000201 11000 0 00000000 3 000 1 00000214 0 0 00000200
setMie      100 300460F3 00000214 00000000 11000 0 00000000 3 000 1 00000218 0 0 00001880
intTrap     100 00000013 00000600 00000000 00110 7 00000000 3 000 1 0000021C 0 0 00000000
mretBack    100 00000013 0000021C 00000000 00001 0 00000000 3 000 1 00000600 0 0 00000000
rdMstatus2  100 300020F3 00000600 00000000 10000 0 00000000 3 000 1 00000604 0 0 00001888
wrMieTimer  100 304090F3 00000604 00000080 11000 0 00000000 3 100 1 00000608 0 0 00000000
pendOn      100 344020F3 00000608 00000000 10000 0 00000000 3 100 1 0000060C 0 1 00000080
timerLow    100 304020F3 0000060C 00000000 10000 0 00000000 3 000 1 00000610 0 0 00000080
clrMieTimer 100 3040B0F3 00000610 00000080 11000 0 00000000 3 100 1 00000614 0 1 00000080
mieOff      100 344020F3 00000614 00000000 10000 0 00000000 3 100 1 00000618 0 0 00000080
wrMieAgain  100 304090F3 00000618 00000080 11000 0 00000000 3 100 1 0000061C 0 0 00000000
clrStatMie  100 300470F3 0000061C 00000000 11000 0 00000000 3 100 1 00000620 0 1 00001888
statMieOff  100 300020F3 00000620 00000000 10000 0 00000000 3 100 1 00000624 0 0 00001880
cycleWrite  100 B00090F3 00000700 00000000 11000 0 00000000 3 000 0 00000704 0 0 x
cycleRd0    100 B00020F3 00000704 00000000 10000 0 00000000 3 000 0 00000708 0 0 00000000
cycleIdle   000 B00020F3 00000708 00000000 00000 0 00000000 3 000 0 0000070C 0 0 x
cycleRd2    100 B00020F3 0000070C 00000000 10000 0 00000000 3 000 0 00000710 0 0 00000002
inhibitCy   100 3200D0F3 00000710 00000000 11000 0 00000000 3 000 1 00000714 0 0 00000000
inhibRd1    100 B00020F3 00000714 00000000 10000 0 00000000 3 000 1 00000718 0 0 00000004
inhibRd2    100 B00020F3 00000718 00000000 10000 0 00000000 3 000 1 0000071C 0 0 00000004
instWrite   100 B02090F3 00000800 00000000 11000 0 00000000 3 000 0 00000804 0 0 x
instStall   110 B02020F3 00000804 00000000 10000 0 00000000 3 000 1 00000808 0 0 x
instFlush   101 B02020F3 00000808 00000000 10000 0 00000000 3 000 1 0000080C 0 0 00000000
instRead    100 B02020F3 0000080C 00000000 10000 0 00000000 3 000 1 00000810 0 0 00000000
instRead2   100 B02020F3 00000810 00000000 10000 0 00000000 3 000 1 00000814 0 0 00000001

// File: verif/csrTb.sv
module csrTb import csrPkg::*; ();

  logic        clk = 1'b0;
  logic        arstN, stallW, flushW, instrValid;
  logic [31:0] instr, pc, pcNextSeq, srcA, badAdr;
  logic        csrRead, csrWrite, trap, interrupt, mret;
  logic        mTimerInt, mExtInt, mSwInt;
  causeT       cause;
  privT        privMode;
  logic [31:0] csrReadValW, pcNext;
  logic        illegalCsrAccess, intPending, statusMie;
  logic [11:0] mieOut, mipOut;

  int errors;     // Checks that failed
  int testCount;
  int testFails;

  csr #(.XLEN(32)) u_dut (.*);

  initial begin
    forever #4 clk = ~clk;
  end

  // Reports a mismatch of expected against actual
  task automatic checkVal(input string test, input string what,
                          input logic [31:0] expVal, input logic [31:0] actVal);
    if (expVal !== actVal) begin
      $display("error %s %s expected %h actual %h", test, what, expVal, actVal);
      errors++;
    end
  endtask

  // Waits for the next falling edge within a few clock events
  task automatic waitNegedge();
    int n;
    n = 0;
    do begin
      @(clk);
      n++;
    end while (clk !== 1'b0 && n < 4);
    if (clk !== 1'b0) begin
      $display("timeout waiting for a falling clock edge");
      $display("Simulation FAILED");
      $finish;
    end
  endtask

  task automatic driveIdle();
    instrValid = 1'b0;
    stallW     = 1'b0;
    flushW     = 1'b0;
    csrRead    = 1'b0;
    csrWrite   = 1'b0;
    trap       = 1'b0;
    interrupt  = 1'b0;
    mret       = 1'b0;
  endtask

  initial begin
    int          fd, r, n, gapLen, errBefore, gap;
    string       line;
    string       test;
    string       expRdStr;
    logic [2:0]  ctl, ints;
    logic [4:0]  ops;
    logic [31:0] vInstr, vPc, vSrc, vBad, expPc, expRd;
    logic [3:0]  vCause;
    logic [1:0]  vPriv;
    logic        expIll, expInt, expRdKnown;
    logic [11:0] expMip;

    r = $urandom(32'h9835);  // Seeds the idle gaps
    errors = 0;
    testCount = 0;
    testFails = 0;
    arstN = 1'b0;
    driveIdle();
    instr     = '0;
    pc        = '0;
    pcNextSeq = 32'd4;
    srcA      = '0;
    badAdr    = '0;
    cause     = '0;
    privMode  = mMode;
    mTimerInt = 1'b0;
    mExtInt   = 1'b0;
    mSwInt    = 1'b0;

    for (int i = 0; i < 2; i++) waitNegedge();  // Two cycles in reset
    arstN = 1'b1;
    waitNegedge();

    fd = $fopen("verif/csrVectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file");
      errors++;
    end else begin
      //////////////////////////////////////////////////
      // One vector per cycle
      //////////////////////////////////////////////////
      while (!$feof(fd)) begin
        line = "";
        r = $fgets(line, fd);
        if (r == 0 || line.len() < 3 || line[0] == "#") continue;  // Header or blank
        n = $sscanf(line, "%s %b %h %h %h %b %h %h %h %b %d %h %b %b %s", test, ctl, vInstr,
                    vPc, vSrc, ops, vCause, vBad, vPriv, ints, gap, expPc, expIll, expInt,
                    expRdStr);
        if (n != 15) begin
          $display("malformed vector line: %s", line);
          errors++;
          continue;
        end
        errBefore  = errors;
        expRdKnown = (expRdStr != "x");  // x marks a value left open
        expRd      = expRdKnown ? expRdStr.atohex() : '0;

        {instrValid, stallW, flushW} = ctl;  // Driven on the falling edge
        {csrRead, csrWrite, trap, interrupt, mret} = ops;
        instr     = vInstr;
        pc        = vPc;
        pcNextSeq = vPc + 32'd4;
        srcA      = vSrc;
        cause     = vCause;
        badAdr    = vBad;
        privMode  = privT'(vPriv);
        {mTimerInt, mExtInt, mSwInt} = ints;

        #2;  // Comb outputs settle mid low phase
        expMip = '0;
        expMip[bitMsi] = ints[0];
        expMip[bitMti] = ints[2];
        expMip[bitMei] = ints[1];
        checkVal(test, "pcNext", expPc, pcNext);
        checkVal(test, "illegalCsrAccess", {31'd0, expIll}, {31'd0, illegalCsrAccess});
        checkVal(test, "intPending", {31'd0, expInt}, {31'd0, intPending});
        checkVal(test, "mipOut", {20'd0, expMip}, {20'd0, mipOut});

        // mie and mstatus.MIE against the value that the same access reads
        if (ctl == 3'b100 && ops[4] && expRdKnown) begin
          if (vInstr[31:20] == adrMie) begin
            checkVal(test, "mieOut", expRd, {20'd0, mieOut});
          end
          if (vInstr[31:20] == adrMstatus) begin
            checkVal(test, "statusMie", {31'd0, expRd[3]}, {31'd0, statusMie});
          end
        end

        waitNegedge();
        if (expRdKnown) begin
          checkVal(test, "csrReadValW", expRd, csrReadValW);  // Old value one cycle later
        end

        testCount++;
        if (errors != errBefore) begin
          testFails++;
          $display("test %s failed", test);
        end else begin
          $display("test %s ok", test);
        end

        if (gap != 0) begin
          driveIdle();
          gapLen = $urandom % 3;  // 0 to 2 idle cycles
          for (int i = 0; i < gapLen; i++) waitNegedge();
        end
      end
      $fclose(fd);
    end

    $display("tests %0d, failed %0d, errors %0d", testCount, testFails, errors);
    if (errors == 0 && testCount > 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: rtl/csr.sv
module csr import csrPkg::*; #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            arstN,
  input  logic            stallW,
  input  logic            flushW,
  input  logic            instrValid,
  input  logic [31:0]     instr,
  input  logic [XLEN-1:0] pc,
  input  logic [XLEN-1:0] pcNextSeq,     // Sequential next pc
  input  logic [XLEN-1:0] srcA,          // rs1 value
  input  logic            csrRead,
  input  logic            csrWrite,
  input  logic            trap,
  input  logic            interrupt,     // Trap is an interrupt
  input  logic            mret,
  input  causeT           cause,
  input  logic [XLEN-1:0] badAdr,        // Faulting load/store address
  input  privT            privMode,
  input  logic            mTimerInt,
  input  logic            mExtInt,
  input  logic            mSwInt,
  output logic [XLEN-1:0] csrReadValW,
  output logic [XLEN-1:0] pcNext,
  output logic            illegalCsrAccess,
  output logic            intPending,
  output logic            statusMie,
  output logic [11:0]     mieOut,
  output logic [11:0]     mipOut
);

  csrAdrT          csrAdr;
  csrOpT           csrOp;
  logic            validNotFlushed;
  logic            trapAccepted;
  logic            mretAccepted;
  logic            insufficientPriv;
  logic [XLEN-1:0] csrSrc;
  logic [XLEN-1:0] oldVal;
  logic [XLEN-1:0] writeVal;
  logic [XLEN-1:0] csrReadValM;
  logic [XLEN-1:0] statusRead, intRead, cntRead, machRead;
  logic            statusIllegal, intIllegal, cntIllegal, machIllegal;
  logic            readOnlyWrite;
  logic [XLEN-1:0] epcNext, causeNext, tvalNext;
  logic [XLEN-1:0] mtvec, mepc;
  logic [XLEN-1:0] tvecBase, trapVec;

  assign csrAdr = instr[31:20];
  assign csrOp  = csrOpT'(instr[13:12]);

  assign validNotFlushed  = instrValid & ~stallW & ~flushW;  // Instruction counts
  assign trapAccepted     = trap & validNotFlushed;
  assign mretAccepted     = mret & validNotFlushed;
  assign insufficientPriv = (csrAdr[9:8] == 2'b11) & (privMode == uMode);

  //////////////////////////////////////////////////
  // Write value
  //////////////////////////////////////////////////

  always_comb begin
    csrSrc = instr[14] ? XLEN'(instr[19:15]) : srcA;  // uimm or rs1
    oldVal = (csrAdr == adrMip) ? '0 : csrReadValM;  // No writable mip bits
    case (csrOp)
      opWrite: writeVal = csrSrc;
      opSet:   writeVal = oldVal | csrSrc;
      opClear: writeVal = oldVal & ~csrSrc;
      default: writeVal = csrReadValM;
    endcase
  end

  csrWriteIf #(.XLEN(XLEN)) wrIf ();

  assign wrIf.adr             = csrAdr;
  assign wrIf.writeVal        = writeVal;
  assign wrIf.writeEn         = csrWrite & validNotFlushed & ~insufficientPriv;
  assign wrIf.validNotFlushed = validNotFlushed;

  // Trap record values
  assign epcNext   = {pc[XLEN-1:1], 1'b0};
  assign causeNext = {interrupt, (XLEN-1)'(cause)};
  always_comb begin
    if (interrupt) tvalNext = '0;
    else begin
      case (cause)
        4'd0, 4'd4, 4'd5, 4'd6, 4'd7: tvalNext = badAdr;  // Address faults
        4'd3:    tvalNext = pc;                             // Breakpoint
        4'd2:    tvalNext = XLEN'(instr);                   // Illegal instruction
        default: tvalNext = '0;
      endcase
    end
  end

  csrStatus #(.XLEN(XLEN)) uStatus (
    .clk, .arstN, .wr(wrIf), .trapAccepted, .mretAccepted, .prevPriv(privMode),
    .statusMie, .readVal(statusRead), .illegal(statusIllegal)
  );

  csrInterrupt #(.XLEN(XLEN)) uInterrupt (
    .clk, .arstN, .wr(wrIf), .mTimerInt, .mExtInt, .mSwInt, .statusMie,
    .mieOut, .mipOut, .intPending, .readVal(intRead), .illegal(intIllegal)
  );

  csrCounter #(.XLEN(XLEN)) uCounter (
    .clk, .arstN, .wr(wrIf), .instrRetired(instrValid & ~trap),
    .readVal(cntRead), .illegal(cntIllegal)
  );

  csrMachine #(.XLEN(XLEN)) uMachine (
    .clk, .arstN, .wr(wrIf), .csrWrite, .trapAccepted, .epcNext, .causeNext, .tvalNext,
    .mtvec, .mepc, .readVal(machRead), .illegal(machIllegal), .readOnlyWrite
  );

  //////////////////////////////////////////////////
  // Next pc, trap then mret then sequential
  //////////////////////////////////////////////////

  assign tvecBase = {mtvec[XLEN-1:2], 2'b00};
  assign trapVec  = (interrupt && mtvec[1:0] == 2'b01) ? tvecBase + (XLEN'(cause) << 2)
                                                       : tvecBase;
  assign pcNext   = trap ? trapVec : (mret ? mepc : pcNextSeq);

  // Merge sub-block answers
  assign csrReadValM      = statusRead | intRead | cntRead | machRead;
  assign illegalCsrAccess = (((statusIllegal & intIllegal & cntIllegal & machIllegal)
                              | insufficientPriv) & csrRead) | readOnlyWrite;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) csrReadValW <= '0;
    else if (flushW) csrReadValW <= '0;
    else if (!stallW) csrReadValW <= csrReadValM;  // Old value to writeback
  end

endmodule

// File: rtl/csrMachine.sv
module csrMachine import csrPkg::*; #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            arstN,
  csrWriteIf.slave        wr,
  input  logic            csrWrite,      // Raw write request, before any check
  input  logic            trapAccepted,
  input  logic [XLEN-1:0] epcNext,       // Faulting pc, bit 0 already clear
  input  logic [XLEN-1:0] causeNext,     // Interrupt flag and cause code
  input  logic [XLEN-1:0] tvalNext,
  output logic [XLEN-1:0] mtvec,
  output logic [XLEN-1:0] mepc,
  output logic [XLEN-1:0] readVal,
  output logic            illegal,
  output logic            readOnlyWrite
);

  logic [XLEN-1:0] mcause;
  logic [XLEN-1:0] mtval;
  logic [XLEN-1:0] mscratch;
  logic            wrTvec;
  logic            wrEpc;
  logic            wrCause;
  logic            wrTval;
  logic            wrScratch;

  assign wrTvec    = wr.writeEn & (wr.adr == adrMtvec);
  assign wrEpc     = wr.writeEn & (wr.adr == adrMepc);
  assign wrCause   = wr.writeEn & (wr.adr == adrMcause);
  assign wrTval    = wr.writeEn & (wr.adr == adrMtval);
  assign wrScratch = wr.writeEn & (wr.adr == adrMscratch);

  // Software-owned registers
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mtvec    <= '0;
      mscratch <= '0;
    end else begin
      if (wrTvec) mtvec <= {wr.writeVal[XLEN-1:2], 1'b0, wr.writeVal[0]};  // Modes 00 and 01
      if (wrScratch) mscratch <= wr.writeVal;
    end
  end

  //////////////////////////////////////////////////
  // Trap record, trap beats a write in the same cycle
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mepc   <= '0;
      mcause <= '0;
      mtval  <= '0;
    end else if (trapAccepted) begin
      mepc   <= epcNext;
      mcause <= causeNext;
      mtval  <= tvalNext;
    end else begin
      if (wrEpc) mepc <= {wr.writeVal[XLEN-1:1], 1'b0};  // Halfword aligned
      if (wrCause) mcause <= wr.writeVal;
      if (wrTval) mtval <= wr.writeVal;
    end
  end

  always_comb begin
    readVal = '0;
    illegal = 1'b0;
    case (wr.adr)
      adrMtvec:    readVal = mtvec;
      adrMepc:     readVal = mepc;
      adrMcause:   readVal = mcause;
      adrMtval:    readVal = mtval;
      adrMscratch: readVal = mscratch;
      adrMhartid:  readVal = '0;  // Single hart
      default:     illegal = 1'b1;
    endcase
  end

  // Top two address bits 11 mark read-only space
  assign readOnlyWrite = csrWrite & (wr.adr[11:10] == 2'b11);

endmodule

// File: rtl/csrCounter.sv
module csrCounter import csrPkg::*; #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            arstN,
  csrWriteIf.slave        wr,
  input  logic            instrRetired,  // Instruction completes without a trap
  output logic [XLEN-1:0] readVal,
  output logic            illegal
);

  localparam bit HasHighHalf = (XLEN == 32);  // RV32 splits the counters

  logic [63:0] mcycle;
  logic [63:0] minstret;
  logic [63:0] cycleNext;
  logic [63:0] instretNext;
  logic        inhibitCy;  // mcountinhibit.CY
  logic        inhibitIr;  // mcountinhibit.IR
  logic        incInstret;
  logic        wrCycle;
  logic        wrCycleh;
  logic        wrInstret;
  logic        wrInstreth;
  logic        wrInhibit;

  assign wrCycle    = wr.writeEn & (wr.adr == adrMcycle);
  assign wrCycleh   = wr.writeEn & (wr.adr == adrMcycleh) & HasHighHalf;
  assign wrInstret  = wr.writeEn & (wr.adr == adrMinstret);
  assign wrInstreth = wr.writeEn & (wr.adr == adrMinstreth) & HasHighHalf;
  assign wrInhibit  = wr.writeEn & (wr.adr == adrMcountinhibit);

  assign incInstret = wr.validNotFlushed & instrRetired & ~inhibitIr;

  //////////////////////////////////////////////////
  // Next counter values, a write beats the increment
  //////////////////////////////////////////////////

  always_comb begin
    cycleNext   = mcycle + {63'd0, ~inhibitCy};
    instretNext = minstret + {63'd0, incInstret};
    if (wrCycle) begin
      cycleNext              = mcycle;
      cycleNext[XLEN-1:0]    = wr.writeVal;
    end
    if (wrCycleh) begin
      cycleNext              = mcycle;
      cycleNext[63:32]       = wr.writeVal[31:0];
    end
    if (wrInstret) begin
      instretNext            = minstret;
      instretNext[XLEN-1:0]  = wr.writeVal;
    end
    if (wrInstreth) begin
      instretNext            = minstret;
      instretNext[63:32]     = wr.writeVal[31:0];
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mcycle    <= '0;
      minstret  <= '0;
      inhibitCy <= 1'b0;
      inhibitIr <= 1'b0;
    end else begin
      mcycle   <= cycleNext;    // Runs through stalls
      minstret <= instretNext;
      if (wrInhibit) begin
        inhibitCy <= wr.writeVal[0];
        inhibitIr <= wr.writeVal[2];  // Bit 1 is time, not here
      end
    end
  end

  always_comb begin
    readVal = '0;
    illegal = 1'b0;
    case (wr.adr)
      adrMcycle:        readVal = mcycle[XLEN-1:0];
      adrMinstret:      readVal = minstret[XLEN-1:0];
      adrMcountinhibit: readVal[2:0] = {inhibitIr, 1'b0, inhibitCy};
      adrMcycleh: begin
        if (HasHighHalf) readVal[31:0] = mcycle[63:32];
        else illegal = 1'b1;  // No high half on RV64
      end
      adrMinstreth: begin
        if (HasHighHalf) readVal[31:0] = minstret[63:32];
        else illegal = 1'b1;
      end
      default:          illegal = 1'b1;
    endcase
  end

endmodule

// File: rtl/csrInterrupt.sv
module csrInterrupt import csrPkg::*; #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            arstN,
  csrWriteIf.slave        wr,
  input  logic            mTimerInt,
  input  logic            mExtInt,
  input  logic            mSwInt,
  input  logic            statusMie,  // Global enable from mstatus
  output logic [11:0]     mieOut,
  output logic [11:0]     mipOut,
  output logic            intPending,
  output logic [XLEN-1:0] readVal,
  output logic            illegal
);

  // Only the three machine-level sources exist
  localparam logic [11:0] IntMask = (12'b1 << bitMsi) | (12'b1 << bitMti) | (12'b1 << bitMei);

  logic [11:0] mie;

  // mip follows the lines directly, nothing to write
  always_comb begin
    mipOut         = '0;
    mipOut[bitMsi] = mSwInt;
    mipOut[bitMti] = mTimerInt;
    mipOut[bitMei] = mExtInt;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mie <= '0;
    end else if (wr.writeEn && (wr.adr == adrMie)) begin
      mie <= wr.writeVal[11:0] & IntMask;  // Unimplemented bits stay zero
    end
  end

  assign mieOut     = mie;
  assign intPending = statusMie & (|(mipOut & mie));  // Enabled and pending

  always_comb begin
    readVal = '0;
    illegal = 1'b0;
    case (wr.adr)
      adrMie:  readVal[11:0] = mie;
      adrMip:  readVal[11:0] = mipOut;
      default: illegal = 1'b1;
    endcase
  end

endmodule

// File: rtl/csrStatus.sv
module csrStatus import csrPkg::*; #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            arstN,
  csrWriteIf.slave        wr,
  input  logic            trapAccepted,  // Trap taken by a counting instruction
  input  logic            mretAccepted,
  input  privT            prevPriv,      // Privilege the trap came from
  output logic            statusMie,
  output logic [XLEN-1:0] readVal,
  output logic            illegal
);

  logic mieBit;
  logic mpieBit;
  privT mpp;
  privT mppWrite;
  logic hit;
  logic writeStatus;

  assign hit         = (wr.adr == adrMstatus);
  assign writeStatus = wr.writeEn & hit;

  // MPP is WARL, only U and M exist
  always_comb begin
    case (wr.writeVal[12:11])
      2'b00:   mppWrite = uMode;
      2'b11:   mppWrite = mMode;
      default: mppWrite = mpp;  // Unsupported level, keep old
    endcase
  end

  // Trap entry wins over mret, mret wins over a software write
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mieBit  <= 1'b0;
      mpieBit <= 1'b0;
      mpp     <= mMode;
    end else if (trapAccepted) begin
      mpieBit <= mieBit;     // Stack the enable
      mieBit  <= 1'b0;
      mpp     <= prevPriv;
    end else if (mretAccepted) begin
      mieBit  <= mpieBit;    // Pop the enable
      mpieBit <= 1'b1;
    end else if (writeStatus) begin
      mieBit  <= wr.writeVal[3];
      mpieBit <= wr.writeVal[7];
      mpp     <= mppWrite;
    end
  end

  assign statusMie = mieBit;

  // Read-back with the fields in place, zero when not addressed
  always_comb begin
    readVal = '0;
    if (hit) begin
      readVal[3]     = mieBit;
      readVal[7]     = mpieBit;
      readVal[12:11] = mpp;
    end
  end

  assign illegal = ~hit;

endmodule

// File: rtl/csrWriteIf.sv
interface csrWriteIf import csrPkg::*; #(
  parameter int XLEN = 32
) ();

  // Decoded access, shared by every CSR sub-block
  csrAdrT          adr;              // Address of the access
  logic [XLEN-1:0] writeVal;         // Value after the RW/RS/RC merge
  logic            writeEn;          // Committed write, privilege already checked
  logic            validNotFlushed;  // Instruction counts this cycle

  // Top drives, sub-blocks only look
  modport master (output adr, writeVal, writeEn, validNotFlushed);
  modport slave  (input  adr, writeVal, writeEn, validNotFlushed);

endinterface

// File: rtl/csrPkg.sv
package csrPkg;

  // Widths that carry a meaning
  typedef logic [11:0] csrAdrT;  // CSR address, instr[31:20]
  typedef logic [3:0]  causeT;   // Trap cause code, low bits of mcause

  // Privilege levels, encoded as in mstatus.MPP
  typedef enum logic [1:0] {
    uMode = 2'b00,
    mMode = 2'b11
  } privT;

  // CSR operation, straight from funct3[1:0]
  typedef enum logic [1:0] {
    opNone  = 2'b00,
    opWrite = 2'b01,  // CSRRW / CSRRWI
    opSet   = 2'b10,  // CSRRS / CSRRSI
    opClear = 2'b11   // CSRRC / CSRRCI
  } csrOpT;

  //////////////////////////////////////////////////
  // Machine CSR addresses
  //////////////////////////////////////////////////

  localparam csrAdrT adrMstatus       = 12'h300;
  localparam csrAdrT adrMie           = 12'h304;
  localparam csrAdrT adrMtvec         = 12'h305;
  localparam csrAdrT adrMcountinhibit = 12'h320;
  localparam csrAdrT adrMscratch      = 12'h340;
  localparam csrAdrT adrMepc          = 12'h341;
  localparam csrAdrT adrMcause        = 12'h342;
  localparam csrAdrT adrMtval         = 12'h343;
  localparam csrAdrT adrMip           = 12'h344;
  localparam csrAdrT adrMcycle        = 12'hB00;
  localparam csrAdrT adrMinstret      = 12'hB02;
  localparam csrAdrT adrMcycleh       = 12'hB80;  // RV32 only
  localparam csrAdrT adrMinstreth     = 12'hB82;  // RV32 only
  localparam csrAdrT adrMhartid       = 12'hF14;  // Read-only space

  // Interrupt bit positions in mie and mip
  localparam int unsigned bitMsi = 3;   // Software
  localparam int unsigned bitMti = 7;   // Timer
  localparam int unsigned bitMei = 11;  // External

endpackage
